// File: all.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_writeback.sv
hw/rv_mem_arbiter.sv
hw/rv_core.sv
sim/rv_tb_memory.sv
sim/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       := rv_core_tb
FILELIST  := all.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

    localparam int CYCLE_LIMIT = 3000;     // 60 instructions at about 50 cycles each
    localparam logic [29:0] MARKER_WORD = 30'h0ff;

    typedef struct packed {
        logic [29:0] addr;
        logic [3:0]  wes;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        rst;
    logic [31:0] data_in;
    logic [31:0] data_out;
    logic [29:0] addr;
    logic [3:0]  wes;

    store_t      expected [$];
    int          errors;
    int          checked;
    int          cycles;
    logic        done;

    rv_core dut (
        .clk(clk), .rst(rst), .data_in(data_in),
        .data_out(data_out), .addr(addr), .wes(wes)
    );

    rv_tb_memory memory (
        .clk(clk), .addr(addr), .wdata(data_out), .wes(wes), .rdata(data_in)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ########################################################################
    // instruction encoders

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic place(input int byte_addr, input logic [31:0] word);
        memory.mem[byte_addr >> 2] = word;
    endtask

    task automatic expect_store(input logic [29:0] a, input logic [3:0] w,
                                input logic [31:0] d);
        expected.push_back('{addr: a, wes: w, data: d});
    endtask

    task automatic load_program;
        place('h00, i_type(12'd512, 0, 0, 1, 7'b0010011));   // x1 is the store base
        place('h04, i_type(-12'sd7, 0, 0, 2, 7'b0010011));
        place('h08, i_type(12'd3, 0, 0, 3, 7'b0010011));
        place('h0c, r_type(7'h00, 3, 2, 0, 4));               // add
        place('h10, s_type(12'd0, 4, 1, 2));
        place('h14, r_type(7'h20, 2, 3, 0, 5));               // sub
        place('h18, s_type(12'd4, 5, 1, 2));
        place('h1c, r_type(7'h00, 3, 2, 1, 6));               // sll
        place('h20, s_type(12'd8, 6, 1, 2));
        place('h24, i_type(12'h401, 2, 5, 7, 7'b0010011));    // srai by 1
        place('h28, s_type(12'd12, 7, 1, 2));
        place('h2c, i_type(12'd28, 2, 5, 8, 7'b0010011));     // srli by 28
        place('h30, s_type(12'd16, 8, 1, 2));
        place('h34, r_type(7'h00, 3, 2, 2, 9));               // slt
        place('h38, r_type(7'h00, 3, 2, 3, 11));              // sltu
        place('h3c, s_type(12'd20, 9, 1, 2));
        place('h40, s_type(12'd24, 11, 1, 2));
        place('h44, i_type(12'h0f0, 2, 4, 13, 7'b0010011));   // xori
        place('h48, i_type(12'h7f0, 13, 7, 14, 7'b0010011));  // andi
        place('h4c, i_type(12'h005, 14, 6, 14, 7'b0010011));  // ori
        place('h50, s_type(12'd28, 14, 1, 2));
        place('h54, {20'h12345, 5'd16, 7'b0110111});          // lui
        place('h58, s_type(12'd32, 16, 1, 2));
        place('h5c, {20'h00001, 5'd17, 7'b0010111});          // auipc
        place('h60, s_type(12'd36, 17, 1, 2));
        place('h64, b_type(13'd8, 3, 3, 0));                  // beq taken
        place('h68, s_type(12'd40, 2, 1, 2));
        place('h6c, b_type(13'd8, 3, 3, 1));                  // bne not taken
        place('h70, s_type(12'd40, 3, 1, 2));
        place('h74, b_type(13'd8, 3, 2, 4));                  // blt taken
        place('h78, s_type(12'd44, 2, 1, 2));
        place('h7c, b_type(13'd8, 3, 2, 7));                  // bgeu taken
        place('h80, s_type(12'd44, 2, 1, 2));
        place('h84, j_type(21'd8, 18));                       // jal
        place('h88, s_type(12'd44, 2, 1, 2));
        place('h8c, s_type(12'd44, 18, 1, 2));
        place('h90, i_type(12'h0a0, 0, 0, 19, 7'b0010011));
        place('h94, i_type(12'd4, 19, 0, 20, 7'b1100111));    // jalr to 0xa4
        place('h98, s_type(12'd48, 2, 1, 2));
        place('h9c, s_type(12'd48, 2, 1, 2));
        place('ha0, s_type(12'd48, 2, 1, 2));
        place('ha4, s_type(12'd48, 20, 1, 2));
        place('ha8, i_type(12'h100, 0, 0, 21, 7'b0010011));   // x21 points at the data word
        place('hac, i_type(12'd1, 21, 0, 22, 7'b0000011));    // lb
        place('hb0, s_type(12'd52, 22, 1, 2));
        place('hb4, i_type(12'd2, 21, 4, 23, 7'b0000011));    // lbu
        place('hb8, s_type(12'd56, 23, 1, 2));
        place('hbc, i_type(12'd0, 21, 0, 24, 7'b0000011));    // lb
        place('hc0, s_type(12'd60, 24, 1, 2));
        place('hc4, i_type(12'd2, 21, 1, 25, 7'b0000011));    // lh
        place('hc8, s_type(12'd64, 25, 1, 2));
        place('hcc, i_type(12'd0, 21, 5, 26, 7'b0000011));    // lhu
        place('hd0, s_type(12'd68, 26, 1, 2));
        place('hd4, i_type(12'd3, 21, 4, 27, 7'b0000011));    // lbu
        place('hd8, s_type(12'd72, 27, 1, 2));
        place('hdc, s_type(12'd73, 2, 1, 0));                 // sb lane 1
        place('he0, s_type(12'd78, 16, 1, 1));                // sh upper half
        place('he4, s_type(12'd76, 3, 1, 0));                 // sb lane 0
        place('he8, i_type(12'd55, 0, 0, 0, 7'b0010011));     // write to x0
        place('hec, s_type(12'd80, 0, 1, 2));
        place('hf0, i_type(12'd0, 21, 2, 28, 7'b0000011));    // lw
        place('hf4, s_type(12'd84, 28, 1, 2));
        place('hf8, s_type(12'd508, 3, 1, 2));                // marker store
        place('hfc, j_type(21'd0, 0));                        // spin here
        place('h100, 32'h8081_f27f);
    endtask

    task automatic build_store_table;
        expect_store(30'h080, 4'hf, 32'hffff_fffc);
        expect_store(30'h081, 4'hf, 32'h0000_000a);
        expect_store(30'h082, 4'hf, 32'hffff_ffc8);
        expect_store(30'h083, 4'hf, 32'hffff_fffc);
        expect_store(30'h084, 4'hf, 32'h0000_000f);
        expect_store(30'h085, 4'hf, 32'h0000_0001);
        expect_store(30'h086, 4'hf, 32'h0000_0000);
        expect_store(30'h087, 4'hf, 32'h0000_0705);
        expect_store(30'h088, 4'hf, 32'h1234_5000);
        expect_store(30'h089, 4'hf, 32'h0000_105c);
        expect_store(30'h08a, 4'hf, 32'h0000_0003);
        expect_store(30'h08b, 4'hf, 32'h0000_0088);
        expect_store(30'h08c, 4'hf, 32'h0000_0098);
        expect_store(30'h08d, 4'hf, 32'hffff_fff2);
        expect_store(30'h08e, 4'hf, 32'h0000_0081);
        expect_store(30'h08f, 4'hf, 32'h0000_007f);
        expect_store(30'h090, 4'hf, 32'hffff_8081);
        expect_store(30'h091, 4'hf, 32'h0000_f27f);
        expect_store(30'h092, 4'hf, 32'h0000_0080);
        expect_store(30'h092, 4'h2, 32'h0000_f900);
        expect_store(30'h093, 4'hc, 32'h5000_0000);
        expect_store(30'h093, 4'h1, 32'h0000_0003);
        expect_store(30'h094, 4'hf, 32'h0000_0000);
        expect_store(30'h095, 4'hf, 32'h8081_f27f);
        expect_store(MARKER_WORD, 4'hf, 32'h0000_0003);
    endtask

    // ########################################################################
    // store checker sampled mid-cycle where the outputs are settled

    always @(negedge clk) begin
        logic [31:0] mask;
        mask = {{8{wes[3]}}, {8{wes[2]}}, {8{wes[1]}}, {8{wes[0]}}};
        if (!rst && wes != 4'h0 && !done) begin
            if (checked >= expected.size()) begin
                $display("more stores than expected, extra store to word %h", addr);
                errors++;
            end else begin
                if (addr != expected[checked].addr) begin
                    $display("error %0t: store %0d word address %h, expected %h",
                             $time, checked, addr, expected[checked].addr);
                    errors++;
                end
                if (wes != expected[checked].wes) begin
                    $display("error %0t: store %0d byte enables %b, expected %b",
                             $time, checked, wes, expected[checked].wes);
                    errors++;
                end
                if ((data_out & mask) != expected[checked].data) begin
                    $display("error %0t: store %0d data %h, expected %h",
                             $time, checked, data_out & mask, expected[checked].data);
                    errors++;
                end
            end
            checked++;
            if (addr == MARKER_WORD) begin
                done = 1'b1;
            end
        end
    end

    initial begin
        rst     = 1'b1;
        errors  = 0;
        checked = 0;
        cycles  = 0;
        done    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            memory.mem[i] = 32'hc0de_0000 | i;
        end
        load_program();
        build_store_table();

        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        while (!done && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end

        if (!done) begin
            $display("the program did not finish within %0d cycles", CYCLE_LIMIT);
            errors++;
        end else if (checked != expected.size()) begin
            $display("the program ended after %0d of %0d stores", checked, expected.size());
            errors++;
        end

        $display("errors: %0d, stores checked: %0d, cycles: %0d", errors, checked, cycles);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim/rv_tb_memory.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_tb_memory (
    input  logic                   clk,
    input  logic [`RV_XLEN-3:0]    addr,
    input  logic [`RV_XLEN-1:0]    wdata,
    input  logic [`RV_XLEN/8-1:0]  wes,
    output logic [`RV_XLEN-1:0]    rdata
);

    // 256 words is enough for the program, its data and the store area
    logic [`RV_XLEN-1:0] mem [256];
    logic [7:0]          index;

    assign index = addr[7:0];

    initial begin
        rdata = '0;
    end

    always @(posedge clk) begin
        rdata <= #1 mem[index];    // read data shows up one cycle after the address
        for (int i = 0; i < `RV_XLEN/8; i++) begin
            if (wes[i]) begin
                mem[index][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`RV_XLEN-1:0]    data_in,
    output logic [`RV_XLEN-1:0]    data_out,
    output logic [`RV_XLEN-3:0]    addr,
    output logic [`RV_XLEN/8-1:0]  wes
);

    rv_pkg::word_t    pc;
    logic             fetch_en;
    logic             fetch_ready;
    logic             fetch_mem_req;
    logic             fetch_mem_ready;
    rv_pkg::word_t    fetch_mem_addr;
    rv_pkg::word_t    fetch_mem_rdata;
    rv_pkg::word_t    fetch_inst;

    logic             dec_en;
    logic             dec_ready;
    rv_pkg::word_t    dec_inst;
    rv_pkg::word_t    dec_pc;
    rv_pkg::decoded_t dec_out;

    logic             exec_en;
    logic             exec_ready;
    rv_pkg::exec_in_t xin;
    rv_pkg::mem_req_t exec_mem;
    logic             exec_mem_req;
    logic             exec_mem_ready;
    rv_pkg::word_t    exec_mem_rdata;
    rv_pkg::word_t    exec_val;
    rv_pkg::word_t    exec_pc_out;
    logic             exec_flush;

    logic             wb_en;
    logic             wb_ready;
    rv_pkg::wb_in_t   win;
    rv_pkg::word_t    regs [`RV_REG_CNT];

    logic             flush_hold;   // execute is parked behind a taken branch or jump
    logic             fetch_start;
    logic             dec_start;
    logic             exec_start;
    logic             wb_start;

    rv_fetch u_fetch (
        .clk(clk), .rst(rst), .en(fetch_en), .pc(pc),
        .mem_ready(fetch_mem_ready), .mem_rdata(fetch_mem_rdata),
        .mem_req(fetch_mem_req), .mem_addr(fetch_mem_addr),
        .inst(fetch_inst), .ready(fetch_ready)
    );

    rv_decode u_decode (
        .clk(clk), .en(dec_en), .inst(dec_inst), .dec(dec_out), .ready(dec_ready)
    );

    rv_execute u_execute (
        .clk(clk), .en(exec_en), .xin(xin),
        .mem_ready(exec_mem_ready), .mem_rdata(exec_mem_rdata),
        .mem(exec_mem), .mem_req(exec_mem_req), .val(exec_val),
        .pc_out(exec_pc_out), .flush(exec_flush), .ready(exec_ready)
    );

    rv_writeback u_writeback (
        .clk(clk), .rst(rst), .en(wb_en), .win(win), .regs(regs), .ready(wb_ready)
    );

    rv_mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .fetch_req(fetch_mem_req), .fetch_addr(fetch_mem_addr),
        .fetch_ready(fetch_mem_ready), .fetch_rdata(fetch_mem_rdata),
        .exec_req(exec_mem_req), .exec(exec_mem),
        .exec_ready(exec_mem_ready), .exec_rdata(exec_mem_rdata),
        .data_in(data_in), .data_out(data_out), .addr(addr), .wes(wes)
    );

    // ########################################################################
    // stage sequencer

    // a stage starts when it is idle and the stage before it has finished
    assign fetch_start = !fetch_en && !fetch_ready;
    assign dec_start   = fetch_en && fetch_ready && !dec_en && !dec_ready;
    assign exec_start  = dec_en && dec_ready && !exec_en && !exec_ready;
    assign wb_start    = exec_en && exec_ready && !wb_en && !wb_ready;

    // later rules override earlier ones so a flush wins over a fetch or decode start
    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= `RV_RESET_PC;
            fetch_en   <= 1'b0;
            dec_en     <= 1'b0;
            exec_en    <= 1'b0;
            wb_en      <= 1'b0;
            flush_hold <= 1'b0;
        end else begin
            if (fetch_start) begin
                fetch_en <= 1'b1;
            end
            if (dec_start) begin
                dec_en   <= 1'b1;
                fetch_en <= 1'b0;
                pc       <= pc + 32'd4;
            end
            if (exec_start) begin
                exec_en <= 1'b1;
                dec_en  <= 1'b0;
            end
            if (wb_start) begin
                wb_en   <= 1'b1;
                exec_en <= 1'b0;
                if (exec_flush) begin
                    pc         <= exec_pc_out;
                    fetch_en   <= 1'b0;
                    dec_en     <= 1'b0;
                    exec_en    <= 1'b1;    // hold execute so nothing younger passes
                    flush_hold <= 1'b1;
                end
            end
            if (wb_en && wb_ready) begin
                wb_en <= 1'b0;
                if (flush_hold) begin
                    exec_en    <= 1'b0;
                    flush_hold <= 1'b0;
                end
            end
        end
    end

    // ########################################################################
    // stage input registers

    always_ff @(posedge clk) begin
        if (dec_start) begin
            dec_inst <= fetch_inst;
            dec_pc   <= pc;
        end
        if (exec_start) begin
            xin <= '{
                dec:     dec_out,
                pc:      dec_pc,
                rs1_val: regs[dec_out.rs1],
                rs2_val: regs[dec_out.rs2]
            };
        end
        if (wb_start) begin
            win <= '{
                op:      xin.dec.op,
                funct3:  xin.dec.funct3,
                rd:      xin.dec.rd,
                addr_lo: exec_mem.addr[1:0],
                val:     exec_val
            };
        end
    end

endmodule

// File: hw/rv_mem_arbiter.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_mem_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  rv_pkg::word_t          fetch_addr,
    output logic                   fetch_ready,
    output rv_pkg::word_t          fetch_rdata,
    input  logic                   exec_req,
    input  rv_pkg::mem_req_t       exec,
    output logic                   exec_ready,
    output rv_pkg::word_t          exec_rdata,
    input  logic [`RV_XLEN-1:0]    data_in,
    output logic [`RV_XLEN-1:0]    data_out,
    output logic [`RV_XLEN-3:0]    addr,
    output logic [`RV_XLEN/8-1:0]  wes
);

    logic busy;         // an access was accepted last cycle
    logic owner_exec;
    logic grant_exec;
    logic grant_fetch;
    logic [`RV_XLEN/8-1:0] lanes;

    assign grant_exec  = !busy && exec_req;
    assign grant_fetch = !busy && !exec_req && fetch_req;

    always_comb begin
        case (exec.width)
            rv_pkg::MEM_BYTE: begin
                lanes    = 4'b0001 << exec.addr[1:0];
                data_out = {4{exec.wdata[7:0]}};
            end
            rv_pkg::MEM_HALF: begin
                lanes    = 4'b0011 << {exec.addr[1], 1'b0};
                data_out = {2{exec.wdata[15:0]}};
            end
            default: begin
                lanes    = 4'b1111;
                data_out = exec.wdata;
            end
        endcase
    end

    assign addr = grant_exec ? exec.addr[`RV_XLEN-1:2] : fetch_addr[`RV_XLEN-1:2];
    assign wes  = (grant_exec && exec.we) ? lanes : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= grant_exec || grant_fetch;
        end
        owner_exec <= grant_exec;
    end

    assign exec_ready  = busy && owner_exec;
    assign fetch_ready = busy && !owner_exec;
    assign exec_rdata  = data_in;
    assign fetch_rdata = data_in;

endmodule

// File: hw/rv_writeback.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_writeback (
    input  logic           clk,
    input  logic           rst,
    input  logic           en,
    input  rv_pkg::wb_in_t win,
    output rv_pkg::word_t  regs [`RV_REG_CNT],
    output logic           ready
);

    rv_pkg::word_t shifted;
    rv_pkg::word_t result;
    logic          we;

    assign shifted = win.val >> {win.addr_lo, 3'b000};

    always_comb begin
        result = win.val;
        if (win.op == rv_pkg::OP_LOAD) begin
            case (rv_pkg::mem_width_e'(win.funct3[1:0]))
                rv_pkg::MEM_BYTE: begin
                    result = {{(`RV_XLEN-8){!win.funct3[2] && shifted[7]}}, shifted[7:0]};
                end
                rv_pkg::MEM_HALF: begin
                    result = {{(`RV_XLEN-16){!win.funct3[2] && shifted[15]}}, shifted[15:0]};
                end
                default: result = win.val;
            endcase
        end
    end

    // one write on the first enabled cycle and x0 is never written
    assign we = en && !ready && win.rd != '0 &&
                win.op != rv_pkg::OP_STORE && win.op != rv_pkg::OP_BRANCH;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b0;
            for (int i = 0; i < `RV_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            ready <= en;
            if (we) begin
                regs[win.rd] <= result;
            end
        end
    end

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_execute (
    input  logic             clk,
    input  logic             en,
    input  rv_pkg::exec_in_t xin,
    input  logic             mem_ready,
    input  rv_pkg::word_t    mem_rdata,
    output rv_pkg::mem_req_t mem,
    output logic             mem_req,
    output rv_pkg::word_t    val,
    output rv_pkg::word_t    pc_out,
    output logic             flush,
    output logic             ready
);

    rv_pkg::decoded_t            d;
    rv_pkg::word_t               a;
    rv_pkg::word_t               b;
    rv_pkg::word_t               alu;
    rv_pkg::word_t               load_word;
    logic signed [`RV_XLEN-1:0]  sra;
    logic [$clog2(`RV_XLEN)-1:0] shamt;
    logic                        is_mem;
    logic                        taken;
    logic                        mem_done;

    assign d      = xin.dec;
    assign a      = xin.rs1_val;
    assign b      = (d.op == rv_pkg::OP_REG) ? xin.rs2_val : d.imm;
    assign shamt  = b[$clog2(`RV_XLEN)-1:0];
    assign sra    = $signed(a) >>> shamt;
    assign is_mem = (d.op == rv_pkg::OP_LOAD) || (d.op == rv_pkg::OP_STORE);

    // ########################################################################
    // ALU and branch compare

    always_comb begin
        case (rv_pkg::alu_f3_e'(d.funct3))
            rv_pkg::F3_ADD:  alu = (d.op == rv_pkg::OP_REG && d.funct7[5]) ? a - b : a + b;
            rv_pkg::F3_SLL:  alu = a << shamt;
            rv_pkg::F3_SLT:  alu = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::F3_SLTU: alu = {{(`RV_XLEN-1){1'b0}}, a < b};
            rv_pkg::F3_XOR:  alu = a ^ b;
            rv_pkg::F3_SR:   alu = d.funct7[5] ? sra : a >> shamt;
            rv_pkg::F3_OR:   alu = a | b;
            rv_pkg::F3_AND:  alu = a & b;
        endcase
    end

    always_comb begin
        case (rv_pkg::br_f3_e'(d.funct3))
            rv_pkg::BR_EQ:  taken = a == xin.rs2_val;
            rv_pkg::BR_NE:  taken = a != xin.rs2_val;
            rv_pkg::BR_LT:  taken = $signed(a) < $signed(xin.rs2_val);
            rv_pkg::BR_GE:  taken = $signed(a) >= $signed(xin.rs2_val);
            rv_pkg::BR_LTU: taken = a < xin.rs2_val;
            rv_pkg::BR_GEU: taken = a >= xin.rs2_val;
            default:        taken = 1'b0;
        endcase
    end

    // ########################################################################
    // results and control flow

    always_comb begin
        flush  = 1'b0;
        pc_out = xin.pc + d.imm;
        case (d.op)
            rv_pkg::OP_LUI:   val = d.imm;
            rv_pkg::OP_AUIPC: val = xin.pc + d.imm;
            rv_pkg::OP_JAL: begin
                val   = xin.pc + 32'd4;
                flush = 1'b1;
            end
            rv_pkg::OP_JALR: begin
                val    = xin.pc + 32'd4;
                flush  = 1'b1;
                pc_out = {mem.addr[`RV_XLEN-1:1], 1'b0};    // rs1+imm with bit 0 cleared
            end
            rv_pkg::OP_BRANCH: begin
                val   = alu;
                flush = taken;
            end
            rv_pkg::OP_LOAD:  val = load_word;
            default:          val = alu;
        endcase
    end

    assign mem = '{
        addr:  a + d.imm,
        wdata: xin.rs2_val,
        we:    d.op == rv_pkg::OP_STORE,
        width: rv_pkg::mem_width_e'(d.funct3[1:0])
    };
    assign mem_req = en && is_mem && !mem_done;

    always_ff @(posedge clk) begin
        if (!en) begin
            mem_done <= 1'b0;
            ready    <= 1'b0;
        end else begin
            if (mem_ready) begin
                mem_done  <= 1'b1;
                load_word <= mem_rdata;     // raw word and writeback picks the lanes
            end
            ready <= !is_mem || mem_ready || mem_done;
        end
    end

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic             clk,
    input  logic             en,
    input  rv_pkg::word_t    inst,
    output rv_pkg::decoded_t dec,
    output logic             ready
);

    rv_pkg::word_t imm;
    logic          known;

    always_comb begin
        known = 1'b1;
        case (rv_pkg::opcode_e'(inst[6:0]))
            rv_pkg::OP_LUI, rv_pkg::OP_AUIPC: begin
                imm = {inst[31:12], 12'b0};
            end
            rv_pkg::OP_JAL: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            rv_pkg::OP_JALR, rv_pkg::OP_LOAD, rv_pkg::OP_IMM: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            rv_pkg::OP_STORE: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rv_pkg::OP_BRANCH: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::OP_REG: begin
                imm = '0;
            end
            default: begin
                imm   = '0;
                known = 1'b0;   // executes as a no-op
            end
        endcase
    end

    always_ff @(posedge clk) begin
        ready <= en;
        if (en) begin
            dec <= '{
                op:     rv_pkg::opcode_e'(inst[6:0]),
                rd:     known ? inst[11:7] : '0,
                rs1:    inst[19:15],
                rs2:    inst[24:20],
                funct3: inst[14:12],
                funct7: inst[31:25],
                imm:    imm
            };
        end
    end

endmodule

// File: hw/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
    input  logic          clk,
    input  logic          rst,
    input  logic          en,
    input  rv_pkg::word_t pc,
    input  logic          mem_ready,
    input  rv_pkg::word_t mem_rdata,
    output logic          mem_req,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t inst,
    output logic          ready
);

    // request only while enabled so that a fetch killed by a flush leaves no
    // stale request behind
    assign mem_req  = en && !ready;
    assign mem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b0;
        end else if (!en) begin
            ready <= 1'b0;
        end else if (mem_ready) begin
            ready <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (en && mem_ready) begin
            inst <= mem_rdata;
        end
    end

endmodule

// File: hw/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_REG_CNT)-1:0] reg_idx_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // width in the low funct3 bits of a load or store while bit 2 marks zero extension
    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_e;

    // integer operations where SRL and SRA share one code and funct7 tells them apart
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_f3_e;

    typedef struct packed {
        opcode_e    op;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm;
    } decoded_t;

    typedef struct packed {
        decoded_t dec;
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
    } exec_in_t;

    typedef struct packed {
        opcode_e    op;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [1:0] addr_lo;    // byte offset of a load
        word_t      val;
    } wb_in_t;

    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        logic       we;
        mem_width_e width;
    } mem_req_t;

endpackage

// File: hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width of the core and of the external memory port
`define RV_XLEN 32

// number of architectural registers
`define RV_REG_CNT 32

// address of the first instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

`endif
